//--- gain_net.f
logic/fixed_pkg.sv
logic/net_pkg.sv
logic/coef_store.sv
logic/feature_buffer.sv
logic/mac_sequencer.sv
logic/tanh_interp.sv
logic/gain_out_queue.sv
logic/gain_net.sv
sim/gain_net_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= gain_net_tb
FILELIST  ?= gain_net.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

PASS_MSG := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/gain_net_tb.sv
`timescale 1ns/1ns

module gain_net_tb;
	import fixed_pkg::*;
	import net_pkg::*;

	localparam int          CLK_PERIOD   = 20;
	localparam int          RESET_CYCLES = 10;
	localparam logic [31:0] SEED         = 32'hd614_e3b7;
	localparam int          N_FRAMES     = 26;
	localparam int          FRAME_BOUND  = 300;
	localparam int          N_LOADS      = 5;
	localparam int          LOAD_BOUND   = 1000;
	// 1024.0 pushes any frame past the saturation point
	localparam sample_t     SAT_WEIGHT   = 32'sh0400_0000;

	logic       clk           = 1'b0;
	logic       rst           = 1'b1;
	logic       load_valid_i  = 1'b0;
	load_word_s load_i        = '0;
	logic       feat_valid_i  = 1'b0;
	sample_t    feat_i        = '0;
	logic       gain_credit_i = 1'b0;
	logic       load_credit_o;
	logic       feat_credit_o;
	logic       gain_valid_o;
	gain_word_s gain_o;

	// reference copies of what the DUT holds
	sample_t bias_m [N_OUT];
	sample_t weight_m [N_WEIGHTS];
	sample_t table_m [TANH_ENTRIES];
	sample_t frame_m [N_IN];
	logic    sigmoid_m;

	// expected gains in arrival order
	sample_t exp_gain [256];
	neuron_t exp_neuron [256];
	int      exp_wr;
	int      exp_rd;

	logic [31:0] rng;
	int          load_sent;
	int          feat_sent;
	logic        withhold_en;
	logic        credit_order_check;
	int          first_returned;

	// monitor side
	int   load_returned;
	int   feat_returned;
	int   gains_received;
	int   frames_begun;
	int   out_credits;
	int   credit_pending;
	logic prev_load_valid;

	// gain credit driver side
	logic [31:0] hold_rng = SEED;
	logic        hold_credits;
	int          stretch_left;
	int          credits_returned;

	gain_net i_dut (
		.clk, .rst, .load_valid_i, .load_i, .load_credit_o,
		.feat_valid_i, .feat_i, .feat_credit_o,
		.gain_valid_o, .gain_o, .gain_credit_i
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = lcg_step(rng);
		return rng;
	endfunction

	// uniform in [-2.0, 2.0)
	function automatic sample_t rand_sample();
		logic [31:0] r;
		r = next_rand();
		return sample_t'({14'b0, r[31:14]}) - 32'sh0002_0000;
	endfunction

	// bias + truncated products, scale, interpolate, saturate, fold
	function automatic sample_t model_gain(input int n);
		sample_t     sum;
		product_t    p;
		sample_t     s;
		logic [31:0] mag;
		int          idx;
		logic [11:0] frac;
		product_t    slope;
		sample_t     interp;
		sample_t     t;
		sum = bias_m[n];
		for (int i = 0; i < N_IN; i++) begin
			p   = product_t'(weight_m[i * N_OUT + n]) * product_t'(frame_m[i]);
			sum = sum + sample_t'(p[47:16]);
		end
		s      = sigmoid_m ? (sum >>> (WEIGHT_SHIFT + 1)) : (sum >>> WEIGHT_SHIFT);
		mag    = (s < 0) ? -s : s;
		idx    = int'(mag[17:12]);
		frac   = mag[11:0];
		slope  = product_t'(table_m[idx + 1] - table_m[idx]) * product_t'(frac);
		interp = table_m[idx] + sample_t'(slope >>> 12);
		if (mag >= 32'h0004_0000)
			t = (s < 0) ? MINUS_ONE : ONE;
		else
			t = (s < 0) ? -interp : interp;
		return sigmoid_m ? ((t >>> 1) + HALF) : t;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] expected);
		if (got !== expected) begin
			$display("Error: %s is %h, expected %h", name, got, expected);
			$display("Test failures found");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "stopped on a protocol failure");
	endtask

	task automatic load_word(input load_kind_e kind, input int addr, input sample_t data);
		load_word_s  w;
		logic [31:0] r;
		w.kind = kind;
		w.addr = coef_addr_t'(addr);
		w.data = data;
		while (load_sent - load_returned >= LOAD_CREDITS) begin
			load_valid_i <= 1'b0;
			@(posedge clk);
		end
		load_valid_i <= 1'b1;
		load_i       <= w;
		load_sent++;
		@(posedge clk);
		// random idle gap of zero to three cycles
		r = next_rand();
		if (r[31:30] != 2'd0) begin
			load_valid_i <= 1'b0;
			repeat (r[31:30]) @(posedge clk);
		end
	endtask

	task automatic finish_load();
		load_valid_i <= 1'b0;
		// the last credit is due one cycle after the last word
		repeat (2) @(posedge clk);
		check_value("load credits held", LOAD_CREDITS - (load_sent - load_returned),
		            LOAD_CREDITS);
	endtask

	// monotonic table with steps below 1/16
	task automatic load_table();
		logic [31:0] r;
		table_m[0] = '0;
		for (int k = 1; k < TANH_ENTRIES; k++) begin
			r          = next_rand();
			table_m[k] = table_m[k - 1] + sample_t'(r[31:20]);
		end
		for (int k = 0; k < TANH_ENTRIES; k++)
			load_word(LOAD_TABLE, k, table_m[k]);
	endtask

	task automatic load_layer(input logic sat);
		for (int n = 0; n < N_OUT; n++) begin
			bias_m[n] = rand_sample();
			load_word(LOAD_BIAS, n, bias_m[n]);
		end
		// even neurons pull up, odd neurons pull down
		for (int a = 0; a < N_WEIGHTS; a++) begin
			if (sat)
				weight_m[a] = ((a % N_OUT) % 2 == 0) ? SAT_WEIGHT : -SAT_WEIGHT;
			else
				weight_m[a] = rand_sample();
			load_word(LOAD_WEIGHT, a, weight_m[a]);
		end
	endtask

	task automatic set_mode(input logic sig);
		load_word(LOAD_MODE, 0, sample_t'(sig));
		finish_load();
		sigmoid_m = sig;
	endtask

	task automatic send_feature(input sample_t value);
		while (feat_sent - feat_returned >= N_IN) begin
			feat_valid_i <= 1'b0;
			@(posedge clk);
		end
		feat_valid_i <= 1'b1;
		feat_i       <= value;
		feat_sent++;
		@(posedge clk);
	endtask

	task automatic run_frame(input logic sat);
		logic [31:0] r;
		// positive features in [0.5, 1.5) for the saturating layer
		for (int i = 0; i < N_IN; i++) begin
			r          = next_rand();
			frame_m[i] = sat ? (HALF + sample_t'(r[31:16])) : rand_sample();
		end
		for (int n = 0; n < N_OUT; n++) begin
			exp_neuron[exp_wr] = neuron_t'(n);
			if (sat)
				exp_gain[exp_wr] = (n % 2 == 0) ? ONE : (sigmoid_m ? sample_t'(0) : MINUS_ONE);
			else
				exp_gain[exp_wr] = model_gain(n);
			exp_wr++;
		end
		for (int i = 0; i < N_IN; i++)
			send_feature(frame_m[i]);
		feat_valid_i <= 1'b0;
	endtask

	task automatic drain();
		while (exp_rd != exp_wr)
			@(posedge clk);
	endtask

	task automatic wait_feat_credits();
		while (feat_returned != feat_sent)
			@(posedge clk);
	endtask

	// outputs sampled half a cycle after the edge
	always @(negedge clk) begin
		if (rst) begin
			exp_rd          = 0;
			load_returned   = 0;
			feat_returned   = 0;
			gains_received  = 0;
			frames_begun    = 0;
			out_credits     = OUT_CREDITS;
			credit_pending  = 0;
			prev_load_valid = 1'b0;
		end else begin
			check_value("load_credit_o", 32'(load_credit_o), 32'(prev_load_valid));
			prev_load_valid = load_valid_i;
			if (load_credit_o)
				load_returned++;
			if (gain_valid_o) begin
				if (out_credits == 0)
					stop_run("gain_valid_o fired while the DUT held no output credit");
				if (exp_rd == exp_wr)
					stop_run("gain_valid_o fired with no gain expected");
				check_value("gain_o.neuron", 32'(gain_o.neuron), 32'(exp_neuron[exp_rd]));
				check_value("gain_o.gain", gain_o.gain, exp_gain[exp_rd]);
				if (gain_o.neuron == '0)
					frames_begun++;
				out_credits--;
				exp_rd++;
				gains_received++;
			end
			// a credit seen now is usable by the DUT two edges later
			out_credits    = out_credits + credit_pending;
			credit_pending = 32'(gain_credit_i);
			if (feat_credit_o) begin
				feat_returned++;
				if (feat_returned > feat_sent)
					stop_run("feat_credit_o pulsed with no feature outstanding");
				if (credit_order_check && feat_returned > N_IN * frames_begun)
					stop_run("feature credits came back before the frame's first gain");
			end
		end
	end

	// gain credits withheld for random stretches when enabled
	always @(posedge clk) begin
		if (rst) begin
			gain_credit_i   <= 1'b0;
			hold_credits     = 1'b0;
			stretch_left     = 0;
			credits_returned = 0;
		end else begin
			if (stretch_left == 0) begin
				hold_rng     = lcg_step(hold_rng);
				hold_credits = withhold_en && hold_rng[31];
				stretch_left = 32'(hold_rng[28:24]);
			end else begin
				stretch_left = stretch_left - 1;
			end
			if (!hold_credits && gains_received > credits_returned) begin
				gain_credit_i <= 1'b1;
				credits_returned++;
			end else begin
				gain_credit_i <= 1'b0;
			end
		end
	end

	initial begin
		#(CLK_PERIOD * (RESET_CYCLES + N_LOADS * LOAD_BOUND + N_FRAMES * FRAME_BOUND));
		stop_run("watchdog expired before the tests completed");
	end

	initial begin
		rng                = SEED;
		exp_wr             = 0;
		load_sent          = 0;
		feat_sent          = 0;
		sigmoid_m          = 1'b0;
		withhold_en        = 1'b0;
		credit_order_check = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		// full load with credits checked by the monitor
		load_table();
		load_layer(1'b0);
		finish_load();

		repeat (5) run_frame(1'b0);
		drain();

		set_mode(1'b1);
		repeat (5) run_frame(1'b0);
		drain();

		// saturation in sigmoid and then tanh
		load_layer(1'b1);
		finish_load();
		repeat (2) run_frame(1'b1);
		drain();
		set_mode(1'b0);
		repeat (2) run_frame(1'b1);
		drain();

		// output back-pressure
		load_layer(1'b0);
		finish_load();
		credit_order_check = 1'b0;
		withhold_en        = 1'b1;
		repeat (6) run_frame(1'b0);
		drain();
		withhold_en = 1'b0;
		wait_feat_credits();
		credit_order_check = 1'b1;

		// back to back frames on feature credits alone
		first_returned = feat_returned;
		repeat (6) run_frame(1'b0);
		drain();
		// the last frame's credits follow its last gain within a few cycles
		repeat (2 * N_IN) @(posedge clk);
		check_value("feat_credit_o pulses", feat_returned - first_returned, 6 * N_IN);

		$display("All tests passed!");
		$finish;
	end

endmodule

//--- logic/gain_net.sv
`timescale 1ns/1ns

module gain_net (
	input  logic                clk,
	input  logic                rst,
	input  logic                load_valid_i,
	input  net_pkg::load_word_s load_i,
	output logic                load_credit_o,
	input  logic                feat_valid_i,
	input  fixed_pkg::sample_t  feat_i,
	output logic                feat_credit_o,
	output logic                gain_valid_o,
	output net_pkg::gain_word_s gain_o,
	input  logic                gain_credit_i
);
	import fixed_pkg::*;
	import net_pkg::*;

	neuron_t      bias_addr;
	coef_addr_t   weight_addr;
	input_idx_t   rd_idx;
	sample_t      bias;
	sample_t      weight;
	sample_t      feat;
	logic         frame_ready;
	logic         frame_done;
	queue_space_t queue_space;
	logic         acc_valid;
	sample_t      acc;
	neuron_t      acc_neuron;
	act_mode_e    mode;
	tanh_idx_t    tab_idx;
	sample_t      tab_lo;
	sample_t      tab_hi;
	logic         act_valid;
	gain_word_s   act_word;

	coef_store i_coef_store (
		.clk, .rst, .load_valid_i, .load_i, .load_credit_o,
		.bias_addr_i(bias_addr), .bias_o(bias),
		.weight_addr_i(weight_addr), .weight_o(weight),
		.tab_idx_i(tab_idx), .tab_lo_o(tab_lo), .tab_hi_o(tab_hi), .mode_o(mode)
	);

	feature_buffer i_feature_buffer (
		.clk, .rst, .feat_valid_i, .feat_i, .feat_credit_o,
		.rd_idx_i(rd_idx), .feat_o(feat),
		.frame_ready_o(frame_ready), .frame_done_i(frame_done)
	);

	mac_sequencer i_mac_sequencer (
		.clk, .rst, .frame_ready_i(frame_ready), .frame_done_o(frame_done),
		.rd_idx_o(rd_idx), .bias_addr_o(bias_addr), .weight_addr_o(weight_addr),
		.bias_i(bias), .weight_i(weight), .feat_i(feat), .queue_space_i(queue_space),
		.acc_valid_o(acc_valid), .acc_o(acc), .acc_neuron_o(acc_neuron)
	);

	tanh_interp i_tanh_interp (
		.clk, .rst, .acc_valid_i(acc_valid), .acc_i(acc), .acc_neuron_i(acc_neuron),
		.mode_i(mode), .tab_idx_o(tab_idx), .tab_lo_i(tab_lo), .tab_hi_i(tab_hi),
		.act_valid_o(act_valid), .act_word_o(act_word)
	);

	gain_out_queue i_gain_out_queue (
		.clk, .rst, .act_valid_i(act_valid), .act_word_i(act_word),
		.queue_space_o(queue_space), .gain_valid_o, .gain_o, .gain_credit_i
	);

endmodule

//--- logic/gain_out_queue.sv
`timescale 1ns/1ns

module gain_out_queue (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  act_valid_i,
	input  net_pkg::gain_word_s   act_word_i,
	output net_pkg::queue_space_t queue_space_o,
	output logic                  gain_valid_o,
	output net_pkg::gain_word_s   gain_o,
	input  logic                  gain_credit_i
);
	import net_pkg::*;

	gain_word_s              mem [N_OUT];
	logic [QUEUE_PTR_W-1:0]  wr_ptr;
	logic [QUEUE_PTR_W-1:0]  rd_ptr;
	queue_space_t            count;
	logic [OUT_CREDIT_W-1:0] credits;
	logic                    pop;

	// send only with a word waiting and a credit in hand
	assign pop = (count != '0) && (credits != '0);

	always_ff @(posedge clk) begin
		if (act_valid_i)
			mem[wr_ptr] <= act_word_i;
		if (pop)
			gain_o <= mem[rd_ptr];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			credits      <= OUT_CREDIT_W'(OUT_CREDITS);
			gain_valid_o <= 1'b0;
		end else begin
			if (act_valid_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count        <= count + queue_space_t'(act_valid_i) - queue_space_t'(pop);
			credits      <= credits + OUT_CREDIT_W'(gain_credit_i) - OUT_CREDIT_W'(pop);
			gain_valid_o <= pop;
		end
	end

	assign queue_space_o = queue_space_t'(N_OUT) - count;

endmodule

//--- logic/tanh_interp.sv
`timescale 1ns/1ns

module tanh_interp (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 acc_valid_i,
	input  fixed_pkg::sample_t   acc_i,
	input  net_pkg::neuron_t     acc_neuron_i,
	input  net_pkg::act_mode_e   mode_i,
	output fixed_pkg::tanh_idx_t tab_idx_o,
	input  fixed_pkg::sample_t   tab_lo_i,
	input  fixed_pkg::sample_t   tab_hi_i,
	output logic                 act_valid_o,
	output net_pkg::gain_word_s  act_word_o
);
	import fixed_pkg::*;
	import net_pkg::*;

	sample_t    scaled;
	logic [31:0] mag;
	logic       s1_valid;
	logic       s1_neg;
	logic       s1_sat;
	logic       s1_sigmoid;
	tanh_idx_t  s1_idx;
	tanh_frac_t s1_frac;
	neuron_t    s1_neuron;
	product_t   slope_prod;
	sample_t    interp;
	sample_t    tanh_val;

	// sigmoid(x) = tanh(x/2)/2 + 1/2, so halve once more here
	assign scaled = (mode_i == ACT_SIGMOID) ? (acc_i >>> (WEIGHT_SHIFT + 1))
	                                        : (acc_i >>> WEIGHT_SHIFT);
	assign mag = scaled[31] ? 32'(-scaled) : 32'(scaled);

	always_ff @(posedge clk) begin
		s1_neg     <= scaled[31];
		s1_sat     <= (mag[31:18] != '0);
		s1_idx     <= mag[17:12];
		s1_frac    <= mag[11:0];
		s1_neuron  <= acc_neuron_i;
		s1_sigmoid <= (mode_i == ACT_SIGMOID);
	end

	// lo + (hi - lo) * frac / 4096
	assign tab_idx_o  = s1_idx;
	assign slope_prod = product_t'(tab_hi_i - tab_lo_i) * product_t'(s1_frac);
	assign interp     = tab_lo_i + sample_t'(slope_prod >>> TANH_FRAC_W);

	always_comb begin
		if (s1_sat)
			tanh_val = s1_neg ? MINUS_ONE : ONE;
		else
			tanh_val = s1_neg ? -interp : interp;
	end

	always_ff @(posedge clk) begin
		act_word_o.neuron <= s1_neuron;
		act_word_o.gain   <= s1_sigmoid ? ((tanh_val >>> 1) + HALF) : tanh_val;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid    <= 1'b0;
			act_valid_o <= 1'b0;
		end else begin
			s1_valid    <= acc_valid_i;
			act_valid_o <= s1_valid;
		end
	end

endmodule

//--- logic/mac_sequencer.sv
`timescale 1ns/1ns

module mac_sequencer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  frame_ready_i,
	output logic                  frame_done_o,
	output net_pkg::input_idx_t   rd_idx_o,
	output net_pkg::neuron_t      bias_addr_o,
	output net_pkg::coef_addr_t   weight_addr_o,
	input  fixed_pkg::sample_t    bias_i,
	input  fixed_pkg::sample_t    weight_i,
	input  fixed_pkg::sample_t    feat_i,
	input  net_pkg::queue_space_t queue_space_i,
	output logic                  acc_valid_o,
	output fixed_pkg::sample_t    acc_o,
	output net_pkg::neuron_t      acc_neuron_o
);
	import fixed_pkg::*;
	import net_pkg::*;

	typedef enum logic [1:0] {IDLE, BIAS, ACCUM, ISSUE} state_e;

	state_e     state;
	neuron_t    neuron_q;
	input_idx_t in_idx_q;
	sample_t    acc_q;
	product_t   prod;
	logic [1:0] issue_pipe;
	logic [1:0] in_flight;
	logic       issue;

	// weight times feature, keep bits 47..16
	assign prod = product_t'(weight_i) * product_t'(feat_i);

	// issued words still inside the two-stage activation pipe
	assign in_flight = 2'(issue_pipe[0]) + 2'(issue_pipe[1]);
	assign issue     = (state == ISSUE) && (queue_space_i > {1'b0, in_flight});

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= IDLE;
			neuron_q   <= '0;
			in_idx_q   <= '0;
			issue_pipe <= '0;
		end else begin
			issue_pipe <= {issue_pipe[0], issue};
			case (state)
				IDLE: begin
					neuron_q <= '0;
					if (frame_ready_i)
						state <= BIAS;
				end
				BIAS: begin
					in_idx_q <= '0;
					state    <= ACCUM;
				end
				ACCUM: begin
					in_idx_q <= in_idx_q + 3'd1;
					if (in_idx_q == input_idx_t'(N_IN - 1))
						state <= ISSUE;
				end
				ISSUE: begin
					// stall here until the queue has room
					if (issue) begin
						neuron_q <= neuron_q + 2'd1;
						if (neuron_q == neuron_t'(N_OUT - 1))
							state <= IDLE;
						else
							state <= BIAS;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == BIAS)
			acc_q <= bias_i;
		else if (state == ACCUM)
			acc_q <= acc_q + sample_t'(prod[47:16]);
	end

	assign rd_idx_o      = in_idx_q;
	assign bias_addr_o   = neuron_q;
	assign weight_addr_o = coef_addr_t'(in_idx_q) * coef_addr_t'(N_OUT) + coef_addr_t'(neuron_q);
	assign acc_valid_o   = issue;
	assign acc_o         = acc_q;
	assign acc_neuron_o  = neuron_q;
	assign frame_done_o  = issue && (neuron_q == neuron_t'(N_OUT - 1));

endmodule

//--- logic/feature_buffer.sv
`timescale 1ns/1ns

module feature_buffer (
	input  logic                clk,
	input  logic                rst,
	input  logic                feat_valid_i,
	input  fixed_pkg::sample_t  feat_i,
	output logic                feat_credit_o,
	input  net_pkg::input_idx_t rd_idx_i,
	output fixed_pkg::sample_t  feat_o,
	output logic                frame_ready_o,
	input  logic                frame_done_i
);
	import fixed_pkg::*;
	import net_pkg::*;

	sample_t                  feat_q [N_IN];
	input_idx_t               wr_ptr;
	logic                     frame_full;
	logic [FEAT_CREDIT_W-1:0] credit_cnt;

	always_ff @(posedge clk) begin
		if (feat_valid_i)
			feat_q[wr_ptr] <= feat_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr        <= '0;
			frame_full    <= 1'b0;
			credit_cnt    <= '0;
			feat_credit_o <= 1'b0;
		end else begin
			if (feat_valid_i) begin
				wr_ptr <= wr_ptr + 3'd1;
				if (wr_ptr == input_idx_t'(N_IN - 1))
					frame_full <= 1'b1;
			end
			// frame consumed, hand all credits back one per cycle
			if (frame_done_i) begin
				frame_full <= 1'b0;
				credit_cnt <= FEAT_CREDIT_W'(N_IN);
			end else if (credit_cnt != '0) begin
				credit_cnt <= credit_cnt - 1'b1;
			end
			feat_credit_o <= (credit_cnt != '0);
		end
	end

	assign feat_o        = feat_q[rd_idx_i];
	assign frame_ready_o = frame_full;

endmodule

//--- logic/coef_store.sv
`timescale 1ns/1ns

module coef_store (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 load_valid_i,
	input  net_pkg::load_word_s  load_i,
	output logic                 load_credit_o,
	input  net_pkg::neuron_t     bias_addr_i,
	output fixed_pkg::sample_t   bias_o,
	input  net_pkg::coef_addr_t  weight_addr_i,
	output fixed_pkg::sample_t   weight_o,
	input  fixed_pkg::tanh_idx_t tab_idx_i,
	output fixed_pkg::sample_t   tab_lo_o,
	output fixed_pkg::sample_t   tab_hi_o,
	output net_pkg::act_mode_e   mode_o
);
	import fixed_pkg::*;
	import net_pkg::*;

	sample_t   bias_q [N_OUT];
	sample_t   weight_q [N_WEIGHTS];
	sample_t   table_q [TANH_ENTRIES];
	act_mode_e mode_q;

	// coefficient writes, out-of-range addresses are dropped
	always_ff @(posedge clk) begin
		if (load_valid_i) begin
			case (load_i.kind)
				LOAD_BIAS: bias_q[neuron_t'(load_i.addr)] <= load_i.data;
				LOAD_WEIGHT: begin
					if (load_i.addr < coef_addr_t'(N_WEIGHTS))
						weight_q[load_i.addr[WEIGHT_AW-1:0]] <= load_i.data;
				end
				LOAD_TABLE: begin
					if (load_i.addr < coef_addr_t'(TANH_ENTRIES))
						table_q[load_i.addr] <= load_i.data;
				end
				default: ;
			endcase
		end
	end

	// one credit back per word, same edge as the write
	always_ff @(posedge clk) begin
		if (rst) begin
			mode_q        <= ACT_TANH;
			load_credit_o <= 1'b0;
		end else begin
			load_credit_o <= load_valid_i;
			if (load_valid_i && load_i.kind == LOAD_MODE)
				mode_q <= act_mode_e'(load_i.data[0]);
		end
	end

	assign bias_o   = bias_q[bias_addr_i];
	assign weight_o = weight_q[weight_addr_i[WEIGHT_AW-1:0]];
	// neighbouring points for interpolation
	assign tab_lo_o = table_q[{1'b0, tab_idx_i}];
	assign tab_hi_o = table_q[{1'b0, tab_idx_i} + 7'd1];
	assign mode_o   = mode_q;

endmodule

//--- logic/net_pkg.sv
package net_pkg;

	// layer shape
	localparam int N_IN      = 8;
	localparam int N_OUT     = 4;
	localparam int N_WEIGHTS = N_IN * N_OUT;
	localparam int WEIGHT_AW = $clog2(N_WEIGHTS);

	// credits held at reset
	localparam int LOAD_CREDITS  = 4;
	localparam int OUT_CREDITS   = 2;
	localparam int FEAT_CREDIT_W = $clog2(N_IN + 1);
	localparam int OUT_CREDIT_W  = $clog2(OUT_CREDITS + 1);
	localparam int QUEUE_PTR_W   = $clog2(N_OUT);

	typedef logic [6:0] coef_addr_t;
	typedef logic [1:0] neuron_t;
	typedef logic [2:0] input_idx_t;
	typedef logic [2:0] queue_space_t;

	typedef enum logic [1:0] {LOAD_BIAS, LOAD_WEIGHT, LOAD_TABLE, LOAD_MODE} load_kind_e;
	typedef enum logic {ACT_TANH, ACT_SIGMOID} act_mode_e;

	// weight for input i, neuron n lives at i * N_OUT + n
	typedef struct packed {
		load_kind_e         kind;
		coef_addr_t         addr;
		fixed_pkg::sample_t data;
	} load_word_s;

	typedef struct packed {
		neuron_t            neuron;
		fixed_pkg::sample_t gain;
	} gain_word_s;

endpackage

//--- logic/fixed_pkg.sv
package fixed_pkg;

	// Q16.16 samples and full-width products
	typedef logic signed [31:0] sample_t;
	typedef logic signed [63:0] product_t;

	localparam int FRAC_BITS = 16;

	localparam sample_t ONE       = 32'sh0001_0000;
	localparam sample_t HALF      = 32'sh0000_8000;
	localparam sample_t MINUS_ONE = -32'sh0001_0000;

	// weight scale 1/256 as a right shift, one more in sigmoid mode
	localparam int WEIGHT_SHIFT = 8;

	// tanh table from 0 to 4 in steps of 1/16
	localparam int TANH_ENTRIES = 65;
	localparam int TANH_FRAC_W  = 12;

	typedef logic [5:0]             tanh_idx_t;
	typedef logic [TANH_FRAC_W-1:0] tanh_frac_t;

endpackage
